// File: Makefile
# Verilator build and run of the main board testbench

TOP := main_board_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): vlog.f $(wildcard src/*.sv verif/*.sv)
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --assert -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: src/bus_pkg.sv
/* main bus definitions
   bus widths, the address map and the two decoded views of a cpu address
*/

package bus_pkg;

    localparam int addr_w = 16;
    localparam int data_w = 8;
    localparam int rom_aw = 17;
    localparam int ram_aw = 11;
    localparam int bank_w = 3;

    // upper five address bits of each page
    localparam logic [4:0] io_page  = 5'h01;  // 0800-0fff
    localparam logic [4:0] ram_page = 5'h03;  // 1800-1fff

    // i/o selector, address bits 10:8
    localparam logic [2:0] io_sel_tone0 = 3'd0;
    localparam logic [2:0] io_sel_tone1 = 3'd1;
    localparam logic [2:0] io_sel_in    = 3'd2;
    localparam logic [2:0] io_sel_sys   = 3'd3;
    localparam logic [2:0] io_sel_bank  = 3'd4;

    // same 16 address bits, seen as an i/o access or as a rom access
    typedef union packed {
        struct packed {
            logic [4:0] page;
            logic [2:0] sel;
            logic [7:0] reg_idx;
        } io;
        struct packed {
            logic        fixed;
            logic        window;
            logic [13:0] offset;
        } rom;
    } bus_addr_u;

endpackage

// File: src/main_board.sv
`timescale 1ns/10ps

/* arcade main board glue
   bus decoder, two tone chips and the mixer that joins them
*/

module main_board import bus_pkg::*, snd_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    bus_valid,
    input  logic                    bus_rnw,
    input  logic [addr_w-1:0]       bus_addr,
    input  logic [data_w-1:0]       bus_wdata,
    output logic                    bus_ready,
    output logic                    rd_valid,
    output logic [data_w-1:0]       rd_data,
    output logic                    rom_cs,
    output logic [rom_aw-1:0]       rom_addr,
    input  logic [data_w-1:0]       rom_data,
    input  logic                    rom_ok,
    input  logic [1:0]              start_button,
    input  logic [1:0]              coin_input,
    input  logic [5:0]              joystick1,
    input  logic [5:0]              joystick2,
    input  logic                    service,
    input  logic [7:0]              dipsw_a,
    output logic signed [snd_w-1:0] snd,
    output logic                    sample
);

    logic [data_w-1:0]        wr_data;
    logic [1:0]               reg_addr;
    logic                     tone0_we;
    logic                     tone1_we;
    logic [data_w-1:0]        tone0_dout;
    logic [data_w-1:0]        tone1_dout;
    logic signed [tone_w-1:0] tone0;
    logic signed [tone_w-1:0] tone1;
    logic                     sample_tick;

    main_decoder u_decoder (
        .clk          (clk),
        .rst          (rst),
        .bus_valid    (bus_valid),
        .bus_rnw      (bus_rnw),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .bus_ready    (bus_ready),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data),
        .rom_cs       (rom_cs),
        .rom_addr     (rom_addr),
        .rom_data     (rom_data),
        .rom_ok       (rom_ok),
        .start_button (start_button),
        .coin_input   (coin_input),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .service      (service),
        .dipsw_a      (dipsw_a),
        .wr_data      (wr_data),
        .reg_addr     (reg_addr),
        .tone0_we     (tone0_we),
        .tone1_we     (tone1_we),
        .tone0_dout   (tone0_dout),
        .tone1_dout   (tone1_dout)
    );

    tone_chip u_tone0 (
        .clk         (clk),
        .rst         (rst),
        .we          (tone0_we),
        .reg_addr    (reg_addr),
        .wr_data     (wr_data),
        .sample_tick (sample_tick),
        .dout        (tone0_dout),
        .tone        (tone0)
    );

    tone_chip u_tone1 (
        .clk         (clk),
        .rst         (rst),
        .we          (tone1_we),
        .reg_addr    (reg_addr),
        .wr_data     (wr_data),
        .sample_tick (sample_tick),
        .dout        (tone1_dout),
        .tone        (tone1)
    );

    snd_mixer u_mixer (
        .clk         (clk),
        .rst         (rst),
        .tone0       (tone0),
        .tone1       (tone1),
        .sample_tick (sample_tick),
        .snd         (snd),
        .sample      (sample)
    );

endmodule

// File: src/main_decoder.sv
`timescale 1ns/10ps

/* main bus decoder
   splits each cpu access into rom, work ram, i/o or unmapped space, holds
   the rom bank and the ram, and answers every accepted read one cycle later
*/

module main_decoder import bus_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              bus_valid,
    input  logic              bus_rnw,
    input  logic [addr_w-1:0] bus_addr,
    input  logic [data_w-1:0] bus_wdata,
    output logic              bus_ready,
    output logic              rd_valid,
    output logic [data_w-1:0] rd_data,
    output logic              rom_cs,
    output logic [rom_aw-1:0] rom_addr,
    input  logic [data_w-1:0] rom_data,
    input  logic              rom_ok,
    input  logic [1:0]        start_button,
    input  logic [1:0]        coin_input,
    input  logic [5:0]        joystick1,
    input  logic [5:0]        joystick2,
    input  logic              service,
    input  logic [7:0]        dipsw_a,
    output logic [data_w-1:0] wr_data,
    output logic [1:0]        reg_addr,
    output logic              tone0_we,
    output logic              tone1_we,
    input  logic [data_w-1:0] tone0_dout,
    input  logic [data_w-1:0] tone1_dout
);

    bus_addr_u         a;
    logic              rom_sel;
    logic              ram_sel;
    logic              io_hit;
    logic              accept;
    logic              rd_acc;
    logic              wr_acc;
    logic [bank_w-1:0] bank;
    logic [data_w-1:0] ram [0:(1 << ram_aw) - 1];
    logic [data_w-1:0] cabinet;
    logic [data_w-1:0] sys_byte;
    logic [data_w-1:0] io_byte;

    assign a       = bus_addr;
    // 8000-ffff fixed, 4000-7fff banked window
    assign rom_sel = a.rom.fixed | a.rom.window;
    assign ram_sel = a.io.page == ram_page;
    assign io_hit  = a.io.page == io_page;

    assign rom_cs   = bus_valid & bus_rnw & rom_sel;
    assign rom_addr = a.rom.fixed ? {{(rom_aw - addr_w + 1){1'b0}}, bus_addr[addr_w-2:0]}
                                  : {bank + bank_w'(2), a.rom.offset};

    // only rom reads can stall
    assign bus_ready = rom_cs ? rom_ok : 1'b1;
    assign accept    = bus_valid & bus_ready;
    assign rd_acc    = accept & bus_rnw;
    assign wr_acc    = accept & ~bus_rnw;

    assign wr_data  = bus_wdata;
    assign reg_addr = a.io.reg_idx[1:0];
    assign tone0_we = wr_acc & io_hit & (a.io.sel == io_sel_tone0);
    assign tone1_we = wr_acc & io_hit & (a.io.sel == io_sel_tone1);

    // joystick bits come in swapped pairwise, as on the original board
    always_comb begin
        if (a.io.reg_idx[0]) begin
            cabinet = {2'b11, joystick1[5:4], joystick1[2], joystick1[3],
                       joystick1[0], joystick1[1]};
        end else begin
            cabinet = {2'b11, joystick2[5:4], joystick2[2], joystick2[3],
                       joystick2[0], joystick2[1]};
        end
    end

    // start buttons idle high, like the unused top bits
    assign sys_byte = {3'b111, start_button, service, coin_input};

    always_comb begin
        case (a.io.sel)
            io_sel_tone0: io_byte = tone0_dout;
            io_sel_tone1: io_byte = tone1_dout;
            io_sel_in:    io_byte = cabinet;
            io_sel_sys:   io_byte = sys_byte;
            // bank port is write only, reads return the dip bank
            io_sel_bank:  io_byte = dipsw_a;
            default:      io_byte = 8'hff;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
            bank     <= '0;
        end else begin
            rd_valid <= rd_acc;
            if (wr_acc && io_hit && a.io.sel == io_sel_bank) begin
                bank <= bus_wdata[bank_w-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_acc && ram_sel) begin
            ram[bus_addr[ram_aw-1:0]] <= bus_wdata;
        end
        if (rd_acc) begin
            if (rom_sel) begin
                rd_data <= rom_data;
            end else if (ram_sel) begin
                rd_data <= ram[bus_addr[ram_aw-1:0]];
            end else if (io_hit) begin
                rd_data <= io_byte;
            end else begin
                rd_data <= 8'hff;
            end
        end
    end

    // a rom read still waiting on the rom gets no response
    assert property (@(posedge clk) disable iff (rst) rom_cs && !rom_ok |=> !rd_valid);

    // writes never reach the rom and never stall
    assert property (@(posedge clk) disable iff (rst)
        bus_valid && !bus_rnw |-> bus_ready && !rom_cs);

endmodule

// File: src/snd_mixer.sv
`timescale 1ns/10ps

/* sound mixer
   sample rate strobe for both tone chips and a clipped sum of their outputs
*/

module snd_mixer import snd_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic signed [tone_w-1:0] tone0,
    input  logic signed [tone_w-1:0] tone1,
    output logic                     sample_tick,
    output logic signed [snd_w-1:0]  snd,
    output logic                     sample
);

    logic [div_w-1:0]        div_cnt;
    logic signed [tone_w:0]  sum;
    logic signed [snd_w-1:0] sat;

    assign sample_tick = div_cnt == div_w'(sample_div - 1);

    // one extra bit so the sum cannot wrap
    assign sum = tone0 + tone1;

    always_comb begin
        if (sum > snd_max) begin
            sat = snd_w'(snd_max);
        end else if (sum < snd_min) begin
            sat = snd_w'(snd_min);
        end else begin
            sat = sum[snd_w-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            snd     <= '0;
            sample  <= 1'b0;
        end else begin
            div_cnt <= sample_tick ? '0 : div_cnt + 1'b1;
            sample  <= sample_tick;
            if (sample_tick) begin
                snd <= sat;
            end
        end
    end

    // sample lands on the first cycle of a new sample period
    assert property (@(posedge clk) disable iff (rst)
        sample |-> div_cnt == '0 && !sample_tick);

endmodule

// File: src/snd_pkg.sv
/* audio path definitions
   sample widths, tone chip register map and the sample rate divider
*/

package snd_pkg;

    localparam int tone_w   = 16;
    localparam int snd_w    = 16;
    localparam int period_w = 12;

    // clock cycles per output sample
    localparam int sample_div = 8;
    localparam int div_w      = $clog2(sample_div);

    // tone chip registers, low two address bits
    localparam logic [1:0] reg_period_lo = 2'd0;
    localparam logic [1:0] reg_period_hi = 2'd1;
    localparam logic [1:0] reg_volume    = 2'd2;

    // clip limits of the mixed output
    localparam int snd_max = 2 ** (snd_w - 1) - 1;
    localparam int snd_min = -(2 ** (snd_w - 1));

endpackage

// File: src/tone_chip.sv
`timescale 1ns/10ps

/* square wave tone chip
   12-bit period and 8-bit volume, phase advanced by the sample tick,
   registers readable on dout
*/

module tone_chip import snd_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     we,
    input  logic [1:0]               reg_addr,
    input  logic [7:0]               wr_data,
    input  logic                     sample_tick,
    output logic [7:0]               dout,
    output logic signed [tone_w-1:0] tone
);

    logic [period_w-1:0]      period;
    logic [7:0]               volume;
    logic [period_w-1:0]      phase;
    logic                     pol;
    logic                     wrap;
    logic                     pol_next;
    logic                     period_wr;
    logic signed [tone_w-1:0] amp;

    assign wrap      = (period != '0) && (phase == period - 1'b1);
    assign pol_next  = wrap ? ~pol : pol;
    assign period_wr = we && (reg_addr == reg_period_lo || reg_addr == reg_period_hi);
    // volume times 128
    assign amp       = $signed({1'b0, volume, 7'd0});

    always_ff @(posedge clk) begin
        if (rst) begin
            period <= '0;
            volume <= '0;
            phase  <= '0;
            pol    <= 1'b0;
            tone   <= '0;
        end else begin
            if (we) begin
                case (reg_addr)
                    reg_period_lo: period[7:0] <= wr_data;
                    reg_period_hi: period[period_w-1:8] <= wr_data[period_w-9:0];
                    reg_volume:    volume <= wr_data;
                    default:       ;
                endcase
            end
            // a new period restarts the count
            if (period_wr) begin
                phase <= '0;
            end else if (sample_tick) begin
                phase <= (wrap || period == '0) ? '0 : phase + 1'b1;
            end
            if (sample_tick) begin
                pol  <= pol_next;
                tone <= pol_next ? amp : -amp;
            end
        end
    end

    always_comb begin
        case (reg_addr)
            reg_period_lo: dout = period[7:0];
            reg_period_hi: dout = {{(16 - period_w){1'b0}}, period[period_w-1:8]};
            reg_volume:    dout = volume;
            // status, current polarity
            default:       dout = {7'd0, pol};
        endcase
    end

    // phase stays inside the period across rewrites
    assert property (@(posedge clk) disable iff (rst) period != '0 |-> phase < period);

endmodule

// File: verif/main_board_tb.sv
`timescale 1ns/10ps

/* main board testbench
   plays the cpu and the program rom, runs rom, ram, input and audio accesses
   while concurrent assertions compare the board against a reference model
*/

module main_board_tb import bus_pkg::*, snd_pkg::*; ();

    logic                    clk;
    logic                    rst;
    logic                    bus_valid;
    logic                    bus_rnw;
    logic [addr_w-1:0]       bus_addr;
    logic [data_w-1:0]       bus_wdata;
    logic                    bus_ready;
    logic                    rd_valid;
    logic [data_w-1:0]       rd_data;
    logic                    rom_cs;
    logic [rom_aw-1:0]       rom_addr;
    logic [data_w-1:0]       rom_data;
    logic                    rom_ok;
    logic [1:0]              start_button;
    logic [1:0]              coin_input;
    logic [5:0]              joystick1;
    logic [5:0]              joystick2;
    logic                    service;
    logic [7:0]              dipsw_a;
    logic signed [snd_w-1:0] snd;
    logic                    sample;

    // reference model of the board state
    bus_addr_u               acc;
    logic [data_w-1:0]       ram_model [0:(1 << ram_aw) - 1];
    logic [7:0]              tone_model [0:1][0:3];
    logic [bank_w-1:0]       bank_model;
    logic [data_w-1:0]       exp_rd;
    logic                    rd_accept;
    logic                    rd_accept_q;
    logic                    rom_req;
    logic                    sat_seen;
    logic                    audio_done;
    int                      sample_cnt;
    int                      amp0;
    int                      amp1;
    int                      mode;
    int                      cycles;
    int                      i;
    integer                  seed;
    logic [addr_w-1:0]       addr;
    string                   test_name;

    tb_clock u_clock (.clk(clk), .rst(rst));

    main_board i_main_board (.*);

    function automatic logic [rom_aw-1:0] rom_addr_for(logic [addr_w-1:0] a,
                                                      logic [bank_w-1:0] b);
        bus_addr_u u;
        u = a;
        if (u.rom.fixed) return {2'b00, a[addr_w-2:0]};
        return {3'(b + 3'd2), u.rom.offset};
    endfunction

    // program rom contents
    function automatic logic [7:0] rom_byte(logic [rom_aw-1:0] a);
        return a[7:0] ^ {5'd0, a[rom_aw-1:rom_aw-3]};
    endfunction

    function automatic logic [7:0] cabinet_byte(logic [5:0] j);
        return {2'b11, j[5:4], j[2], j[3], j[0], j[1]};
    endfunction

    function automatic logic [data_w-1:0] expected_read(logic [addr_w-1:0] a);
        bus_addr_u u;
        u = a;
        if (u.rom.fixed || u.rom.window) return rom_byte(rom_addr_for(a, bank_model));
        if (u.io.page == ram_page) return ram_model[a[ram_aw-1:0]];
        if (u.io.page != io_page) return 8'hff;
        case (u.io.sel)
            io_sel_tone0: return tone_model[0][u.io.reg_idx[1:0]];
            io_sel_tone1: return tone_model[1][u.io.reg_idx[1:0]];
            io_sel_in:    return cabinet_byte(u.io.reg_idx[0] ? joystick1 : joystick2);
            io_sel_sys:   return {3'b111, start_button, service, coin_input};
            io_sel_bank:  return dipsw_a;
            default:      return 8'hff;
        endcase
    endfunction

    function automatic logic [addr_w-1:0] io_addr(logic [2:0] sel, logic [7:0] idx);
        bus_addr_u u;
        u.io.page    = io_page;
        u.io.sel     = sel;
        u.io.reg_idx = idx;
        return u;
    endfunction

    function automatic int clip(int v);
        if (v > snd_max) return snd_max;
        if (v < snd_min) return snd_min;
        return v;
    endfunction

    // every sign combination of the two square waves
    function automatic logic mix_ok(int s, int a, int b);
        return s == clip(a + b) || s == clip(a - b) || s == clip(b - a) || s == clip(-a - b);
    endfunction

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(string what, int expected, int actual);
        $display("Error: %s: %s expected %0d actual %0d", test_name, what, expected, actual);
        abort_run();
    endtask

    // one cpu access, the rom stall is drawn per request
    task automatic bus_access(input logic rnw, input logic [addr_w-1:0] a,
                              input logic [data_w-1:0] wdata);
        int   stall;
        logic done;
        bus_valid = 1'b1;
        bus_rnw   = rnw;
        bus_addr  = a;
        bus_wdata = wdata;
        stall     = $unsigned($random(seed)) % 4;
        rom_ok    = (stall == 0);
        done      = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = bus_ready;
            @(posedge clk);
            #1;
            stall  = stall - 1;
            rom_ok = (stall <= 0);
        end
        bus_valid = 1'b0;
        rom_ok    = 1'b0;
    endtask

    task automatic wait_samples(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge clk);
            if (sample) seen++;
        end
        @(posedge clk);
        #1;
    endtask

    assign rom_data  = rom_byte(rom_addr);
    assign acc       = bus_addr;
    assign rd_accept = bus_valid & bus_ready & bus_rnw;
    // rom space is 8000-ffff plus the 4000-7fff window
    assign rom_req   = bus_valid & bus_rnw & (acc.rom.fixed | acc.rom.window);
    assign amp0      = 128 * int'(tone_model[0][reg_volume]);
    assign amp1      = 128 * int'(tone_model[1][reg_volume]);

    always @(posedge clk) begin
        if (rst) begin
            bank_model  <= '0;
            rd_accept_q <= 1'b0;
            sat_seen    <= 1'b0;
            sample_cnt  <= 0;
            tone_model  <= '{default: 8'h00};
        end else begin
            rd_accept_q <= rd_accept;
            // cycles into the current sample period, counted from reset
            sample_cnt  <= (sample_cnt == sample_div) ? 1 : sample_cnt + 1;
            if (sample && (snd == snd_max || snd == snd_min)) sat_seen <= 1'b1;
            if (rd_accept) begin
                exp_rd <= expected_read(bus_addr);
            end else if (bus_valid && bus_ready) begin
                if (acc.io.page == ram_page) begin
                    ram_model[bus_addr[ram_aw-1:0]] <= bus_wdata;
                end else if (acc.io.page == io_page && acc.io.sel == io_sel_bank) begin
                    bank_model <= bus_wdata[bank_w-1:0];
                end else if (acc.io.page == io_page && acc.io.sel[2:1] == 2'b00) begin
                    // only the low nibble of the period high byte exists
                    tone_model[acc.io.sel[0]][acc.io.reg_idx[1:0]] <=
                        (acc.io.reg_idx[1:0] == reg_period_hi) ? bus_wdata & 8'h0f : bus_wdata;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 4000) begin
            $display("Error: run timed out after %0d cycles", cycles);
            abort_run();
        end
    end

    assert property (@(posedge clk) disable iff (rst) rom_cs == rom_req)
        else report_mismatch("rom_cs", $sampled(rom_req), $sampled(rom_cs));
    assert property (@(posedge clk) disable iff (rst) bus_ready == !(rom_req && !rom_ok))
        else report_mismatch("bus_ready", $sampled(!(rom_req && !rom_ok)),
                             $sampled(bus_ready));
    assert property (@(posedge clk) disable iff (rst) rd_valid == rd_accept_q)
        else report_mismatch("rd_valid", $sampled(rd_accept_q), $sampled(rd_valid));
    assert property (@(posedge clk) disable iff (rst) rd_valid |-> rd_data == exp_rd)
        else report_mismatch("rd_data", $sampled(exp_rd), $sampled(rd_data));
    assert property (@(posedge clk) disable iff (rst)
        rom_cs |-> rom_addr == rom_addr_for(bus_addr, bank_model))
        else report_mismatch("rom_addr", $sampled(rom_addr_for(bus_addr, bank_model)),
                             $sampled(rom_addr));
    assert property (@(posedge clk) disable iff (rst) sample == (sample_cnt == sample_div))
        else report_mismatch("sample", $sampled(sample_cnt == sample_div), $sampled(sample));
    assert property (@(posedge clk) disable iff (rst)
        (sample && mode == 0) || $past(rst) |-> snd == 0)
        else report_mismatch("silent snd", 0, $sampled(snd));
    assert property (@(posedge clk) disable iff (rst)
        sample && mode == 1 |-> snd == amp0 || snd == -amp0)
        else report_mismatch("snd magnitude", $sampled(amp0), $sampled(snd));
    assert property (@(posedge clk) disable iff (rst)
        sample && mode == 2 |-> mix_ok(snd, amp0, amp1))
        else report_mismatch("clipped snd", clip($sampled(amp0 + amp1)), $sampled(snd));
    assert property (@(posedge clk) disable iff (rst) audio_done |-> sat_seen)
        else begin
            $display("Error: %s: mixer output never reached full scale", test_name);
            abort_run();
        end

    initial begin
        seed         = 32'h50a2;
        cycles       = 0;
        mode         = 0;
        audio_done   = 1'b0;
        test_name    = "reset";
        bus_valid    = 1'b0;
        bus_rnw      = 1'b1;
        bus_addr     = '0;
        bus_wdata    = '0;
        rom_ok       = 1'b0;
        start_button = 2'b11;
        coin_input   = 2'b00;
        joystick1    = 6'h15;
        joystick2    = 6'h2a;
        service      = 1'b1;
        dipsw_a      = 8'h5c;
        wait (!rst);
        @(posedge clk);
        #1;

        test_name = "fixed rom";
        for (i = 0; i < 8; i++) bus_access(1'b1, 16'h8000 | 16'($random(seed)), 8'h00);

        test_name = "banked rom";
        for (i = 0; i < 8; i++) begin
            bus_access(1'b0, io_addr(io_sel_bank, 8'h00), 8'(i));
            bus_access(1'b1, 16'h4000 | (16'($random(seed)) & 16'h3fff), 8'h00);
        end

        test_name = "ram";
        for (i = 0; i < 8; i++) begin
            addr = 16'h1800 | (16'($random(seed)) & 16'h07ff);
            bus_access(1'b0, addr, 8'($random(seed)));
            bus_access(1'b1, addr, 8'h00);
        end
        bus_access(1'b1, 16'h0000, 8'h00);
        bus_access(1'b1, 16'h1000, 8'h00);
        bus_access(1'b1, io_addr(3'd5, 8'h00), 8'h00);

        test_name = "inputs";
        for (i = 0; i < 3; i++) begin
            joystick1    = 6'($random(seed));
            joystick2    = 6'($random(seed));
            coin_input   = 2'($random(seed));
            start_button = 2'($random(seed));
            service      = 1'($random(seed));
            dipsw_a      = 8'($random(seed));
            bus_access(1'b1, io_addr(io_sel_in, 8'h00), 8'h00);
            bus_access(1'b1, io_addr(io_sel_in, 8'h01), 8'h00);
            bus_access(1'b1, io_addr(io_sel_sys, 8'h00), 8'h00);
            bus_access(1'b1, io_addr(io_sel_bank, 8'h00), 8'h00);
        end

        test_name = "tone registers";
        bus_access(1'b0, io_addr(io_sel_tone0, 8'(reg_period_lo)), 8'ha5);
        bus_access(1'b0, io_addr(io_sel_tone1, 8'(reg_period_hi)), 8'h0c);
        bus_access(1'b1, io_addr(io_sel_tone0, 8'(reg_period_lo)), 8'h00);
        bus_access(1'b1, io_addr(io_sel_tone1, 8'(reg_period_hi)), 8'h00);
        // unequal periods so every polarity pair shows up
        bus_access(1'b0, io_addr(io_sel_tone0, 8'(reg_period_lo)), 8'h02);
        bus_access(1'b0, io_addr(io_sel_tone1, 8'(reg_period_lo)), 8'h03);
        bus_access(1'b0, io_addr(io_sel_tone1, 8'(reg_period_hi)), 8'h00);
        wait_samples(4);

        test_name = "single tone";
        mode = 3;
        bus_access(1'b0, io_addr(io_sel_tone0, 8'(reg_volume)), 8'h91);
        bus_access(1'b1, io_addr(io_sel_tone0, 8'(reg_volume)), 8'h00);
        wait_samples(3);
        mode = 1;
        wait_samples(16);

        test_name = "saturation";
        mode = 3;
        bus_access(1'b0, io_addr(io_sel_tone0, 8'(reg_volume)), 8'hff);
        bus_access(1'b0, io_addr(io_sel_tone1, 8'(reg_volume)), 8'hff);
        bus_access(1'b1, io_addr(io_sel_tone1, 8'(reg_volume)), 8'h00);
        wait_samples(3);
        mode = 2;
        wait_samples(24);
        audio_done = 1'b1;
        repeat (2) @(posedge clk);
        $display("Regression passed");
        $finish;
    end

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/10ps

/* testbench clock and reset
   10 ns clock, reset held for the first three rising edges
*/

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: vlog.f
src/bus_pkg.sv
src/snd_pkg.sv
src/main_decoder.sv
src/tone_chip.sv
src/snd_mixer.sv
src/main_board.sv
verif/tb_clock.sv
verif/main_board_tb.sv
